/* Makefile */
TOP = wisc_core_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o sim
	out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qx "All tests passed"

lint:
	verilator --lint-only --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* compile.f */
logic/wisc_pkg.sv
logic/wisc_decode.sv
logic/wisc_execute.sv
logic/wisc_result.sv
logic/wisc_core.sv
tests/wisc_core_tb.sv

/* logic/wisc_core.sv */
// WISC three-stage core
`timescale 1ns/1ns

module wisc_core (
	input  logic                clk,
	input  logic                rst,
	input  logic                instr_valid,
	input  wisc_pkg::instr_t    instr,
	output logic                wb_valid,
	output wisc_pkg::reg_idx_t  wb_rd,
	output wisc_pkg::word_t     wb_data
);

	logic               dec_valid;
	wisc_pkg::opcode_t  dec_op;
	wisc_pkg::reg_idx_t dec_rd;
	wisc_pkg::word_t    dec_a;
	wisc_pkg::word_t    dec_b;
	wisc_pkg::shamt_t   dec_shamt;
	logic               alu_valid;	// Execute forward path
	wisc_pkg::reg_idx_t alu_rd;
	wisc_pkg::word_t    alu_data;
	logic               ex_valid;	// Commit forward path
	wisc_pkg::reg_idx_t ex_rd;
	wisc_pkg::word_t    ex_data;
	wisc_pkg::reg_idx_t rd_addr_a;
	wisc_pkg::reg_idx_t rd_addr_b;
	wisc_pkg::word_t    rd_data_a;
	wisc_pkg::word_t    rd_data_b;

	wisc_decode wisc_decode_i (
		.clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
		.alu_valid(alu_valid), .alu_rd(alu_rd), .alu_data(alu_data),
		.ex_valid(ex_valid), .ex_rd(ex_rd), .ex_data(ex_data),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.dec_valid(dec_valid), .dec_op(dec_op), .dec_rd(dec_rd),
		.dec_a(dec_a), .dec_b(dec_b), .dec_shamt(dec_shamt));

	wisc_execute wisc_execute_i (
		.clk(clk), .rst(rst), .dec_valid(dec_valid), .dec_op(dec_op),
		.dec_rd(dec_rd), .dec_a(dec_a), .dec_b(dec_b), .dec_shamt(dec_shamt),
		.alu_valid(alu_valid), .alu_rd(alu_rd), .alu_data(alu_data),
		.ex_valid(ex_valid), .ex_rd(ex_rd), .ex_data(ex_data));

	wisc_result wisc_result_i (
		.clk(clk), .rst(rst), .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_data(ex_data),
		.rd_addr_a(rd_addr_a), .rd_addr_b(rd_addr_b),
		.rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
		.wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data));

endmodule

/* logic/wisc_decode.sv */
// WISC decode stage
`timescale 1ns/1ns

module wisc_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                instr_valid,
	input  wisc_pkg::instr_t    instr,
	input  logic                alu_valid,	// Instruction now in execute
	input  wisc_pkg::reg_idx_t  alu_rd,
	input  wisc_pkg::word_t     alu_data,
	input  logic                ex_valid,	// Instruction waiting to commit
	input  wisc_pkg::reg_idx_t  ex_rd,
	input  wisc_pkg::word_t     ex_data,
	input  wisc_pkg::word_t     rd_data_a,
	input  wisc_pkg::word_t     rd_data_b,
	output wisc_pkg::reg_idx_t  rd_addr_a,
	output wisc_pkg::reg_idx_t  rd_addr_b,
	output logic                dec_valid,
	output wisc_pkg::opcode_t   dec_op,
	output wisc_pkg::reg_idx_t  dec_rd,
	output wisc_pkg::word_t     dec_a,
	output wisc_pkg::word_t     dec_b,
	output wisc_pkg::shamt_t    dec_shamt
);

	wisc_pkg::opcode_t  op;
	wisc_pkg::reg_idx_t rd;
	wisc_pkg::reg_idx_t rs;
	wisc_pkg::reg_idx_t rt;
	wisc_pkg::shamt_t   shamt;
	wisc_pkg::imm8_t    imm;
	logic               writes;	// Opcode produces a register result
	wisc_pkg::word_t    fwd_a;
	wisc_pkg::word_t    fwd_b;
	wisc_pkg::word_t    opnd_a;
	wisc_pkg::word_t    opnd_b;

	// Execute result beats pending commit beats register file
	function automatic wisc_pkg::word_t forward(input wisc_pkg::reg_idx_t idx,
		input wisc_pkg::word_t rf_data);
		wisc_pkg::word_t val;
		if (alu_valid && alu_rd == idx) begin
			val = alu_data;
		end else if (ex_valid && ex_rd == idx) begin
			val = ex_data;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	assign op    = wisc_pkg::opcode_t'(instr[wisc_pkg::OPC_HI:wisc_pkg::OPC_LO]);
	assign rd    = instr[wisc_pkg::RD_HI:wisc_pkg::RD_LO];
	assign rs    = instr[wisc_pkg::RS_HI:wisc_pkg::RS_LO];
	assign rt    = instr[wisc_pkg::RT_HI:wisc_pkg::RT_LO];
	assign shamt = instr[wisc_pkg::RT_HI:wisc_pkg::RT_LO];
	assign imm   = instr[wisc_pkg::IMM_HI:wisc_pkg::IMM_LO];

	assign rd_addr_a = rs;
	assign rd_addr_b = (op == wisc_pkg::OP_LHB) ? rd : rt;	// LHB keeps low byte of rd

	always_comb begin
		fwd_a = forward(rd_addr_a, rd_data_a);
		fwd_b = forward(rd_addr_b, rd_data_b);
	end

	always_comb begin
		case (op)
			wisc_pkg::OP_ADD, wisc_pkg::OP_SUB, wisc_pkg::OP_AND, wisc_pkg::OP_NOR,
			wisc_pkg::OP_SLL, wisc_pkg::OP_SRL, wisc_pkg::OP_SRA,
			wisc_pkg::OP_LLB, wisc_pkg::OP_LHB: writes = 1'b1;
			wisc_pkg::OP_NOP: writes = 1'b0;
			default: writes = 1'b0;	// Undefined codes
		endcase
	end

	// Immediates replace the forwarded operands
	always_comb begin
		opnd_a = fwd_a;
		opnd_b = fwd_b;
		if (op == wisc_pkg::OP_LLB) begin
			opnd_b = {{8{imm[7]}}, imm};	// Sign extend
		end else if (op == wisc_pkg::OP_LHB) begin
			opnd_a = {imm, 8'h00};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid && writes && (rd != '0);	// r0 writes dropped here
		end
	end

	always_ff @(posedge clk) begin
		dec_op    <= op;
		dec_rd    <= rd;
		dec_a     <= opnd_a;
		dec_b     <= opnd_b;
		dec_shamt <= shamt;
	end

	a_instr_known: assert property (@(posedge clk) disable iff (rst)
		instr_valid |-> !$isunknown(instr));

endmodule

/* logic/wisc_execute.sv */
// WISC execute stage
`timescale 1ns/1ns

module wisc_execute (
	input  logic                clk,
	input  logic                rst,
	input  logic                dec_valid,
	input  wisc_pkg::opcode_t   dec_op,
	input  wisc_pkg::reg_idx_t  dec_rd,
	input  wisc_pkg::word_t     dec_a,
	input  wisc_pkg::word_t     dec_b,
	input  wisc_pkg::shamt_t    dec_shamt,
	output logic                alu_valid,	// Forward to decode
	output wisc_pkg::reg_idx_t  alu_rd,
	output wisc_pkg::word_t     alu_data,
	output logic                ex_valid,	// Pending commit
	output wisc_pkg::reg_idx_t  ex_rd,
	output wisc_pkg::word_t     ex_data
);

	wisc_pkg::word_t result;

	always_comb begin
		case (dec_op)
			wisc_pkg::OP_ADD: begin
				result = dec_a + dec_b;	// Wraps at 16 bits
			end
			wisc_pkg::OP_SUB: begin
				result = dec_a - dec_b;
			end
			wisc_pkg::OP_AND: begin
				result = dec_a & dec_b;
			end
			wisc_pkg::OP_NOR: begin
				result = ~(dec_a | dec_b);
			end
			wisc_pkg::OP_SLL: begin
				result = dec_a << dec_shamt;
			end
			wisc_pkg::OP_SRL: begin
				result = dec_a >> dec_shamt;
			end
			wisc_pkg::OP_SRA: begin
				result = $signed(dec_a) >>> dec_shamt;	// Copies the sign bit
			end
			wisc_pkg::OP_LLB: begin
				result = dec_b;	// Already sign extended
			end
			wisc_pkg::OP_LHB: begin
				result = {dec_a[15:8], dec_b[7:0]};
			end
			default: begin
				result = '0;	// NOP never reaches here valid
			end
		endcase
	end

	assign alu_valid = dec_valid;
	assign alu_rd    = dec_rd;
	assign alu_data  = result;

	always_ff @(posedge clk) begin
		if (rst) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= dec_valid;
		end
	end

	always_ff @(posedge clk) begin
		ex_rd   <= dec_rd;
		ex_data <= result;
	end

	// Decode must have dropped r0 destinations
	a_ex_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
		ex_valid |-> ex_rd != '0);

endmodule

/* logic/wisc_pkg.sv */
// WISC core shared types
package wisc_pkg;

	typedef logic [15:0] word_t;	// Register and ALU data
	typedef logic [3:0]  reg_idx_t;	// Register number, r0 reads zero
	typedef logic [15:0] instr_t;
	typedef logic [7:0]  imm8_t;	// LLB and LHB byte immediate
	typedef logic [3:0]  shamt_t;

	// Unlisted codes decode as NOP
	typedef enum logic [3:0] {
		OP_ADD = 4'd0,
		OP_SUB = 4'd1,
		OP_AND = 4'd2,
		OP_NOR = 4'd3,
		OP_SLL = 4'd4,
		OP_SRL = 4'd5,
		OP_SRA = 4'd6,
		OP_LLB = 4'd7,
		OP_LHB = 4'd8,
		OP_NOP = 4'd15
	} opcode_t;

	// Instruction field positions
	localparam int OPC_HI = 15;
	localparam int OPC_LO = 12;
	localparam int RD_HI  = 11;
	localparam int RD_LO  = 8;
	localparam int RS_HI  = 7;
	localparam int RS_LO  = 4;
	localparam int RT_HI  = 3;	// Also the shift amount
	localparam int RT_LO  = 0;
	localparam int IMM_HI = 7;
	localparam int IMM_LO = 0;

endpackage

/* logic/wisc_result.sv */
// WISC result stage and register file
`timescale 1ns/1ns

module wisc_result (
	input  logic                clk,
	input  logic                rst,
	input  logic                ex_valid,
	input  wisc_pkg::reg_idx_t  ex_rd,
	input  wisc_pkg::word_t     ex_data,
	input  wisc_pkg::reg_idx_t  rd_addr_a,
	input  wisc_pkg::reg_idx_t  rd_addr_b,
	output wisc_pkg::word_t     rd_data_a,
	output wisc_pkg::word_t     rd_data_b,
	output logic                wb_valid,
	output wisc_pkg::reg_idx_t  wb_rd,
	output wisc_pkg::word_t     wb_data
);

	wisc_pkg::word_t regs [1:15];	// r1 to r15

	// Asynchronous reads, r0 is hardwired to zero
	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 16; i++) begin
				regs[i] <= '0;	// Architectural state starts at zero
			end
		end else if (ex_valid) begin
			regs[ex_rd] <= ex_data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= ex_valid;	// Report the commit
		end
	end

	always_ff @(posedge clk) begin
		wb_rd   <= ex_rd;
		wb_data <= ex_data;
	end

	a_wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
		wb_valid |-> wb_rd != '0);

endmodule

/* tests/wisc_core_tb.sv */
// WISC core testbench
`timescale 1ns/1ns

module wisc_core_tb;

	localparam int NUM_VEC     = 38;
	localparam int LATENCY     = 3;	// Drive to writeback, in cycles
	localparam int DRAIN_LIMIT = 50;
	localparam int RESET_CYCLES = 16;

	logic               clk;
	logic               rst;
	logic               instr_valid;
	wisc_pkg::instr_t   instr;
	logic               wb_valid;
	wisc_pkg::reg_idx_t wb_rd;
	wisc_pkg::word_t    wb_data;

	logic [19:0] vec_mem [0:4*NUM_VEC-1];	// Four fields per vector

	int cycle = 0;	// Rising edges so far
	int value_errors = 0;
	int protocol_errors = 0;
	int checked = 0;

	// Expected writebacks, oldest first
	int                 exp_cycle [$];
	wisc_pkg::reg_idx_t exp_rd [$];
	wisc_pkg::word_t    exp_data [$];

	wisc_core wisc_core_i (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instr(instr),
		.wb_valid(wb_valid),
		.wb_rd(wb_rd),
		.wb_data(wb_data)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
	end

	task automatic check_rd(input wisc_pkg::reg_idx_t got, input wisc_pkg::reg_idx_t exp);
		if (got !== exp) begin
			$display("FAILED wb_rd: got %h, expected %h at cycle %0d", got, exp, cycle);
			value_errors++;
		end
	endtask

	task automatic check_data(input wisc_pkg::word_t got, input wisc_pkg::word_t exp);
		if (got !== exp) begin
			$display("FAILED wb_data: got %h, expected %h at cycle %0d", got, exp, cycle);
			value_errors++;
		end
	endtask

	task automatic drop_head();
		void'(exp_cycle.pop_front());
		void'(exp_rd.pop_front());
		void'(exp_data.pop_front());
	endtask

	// Writeback outputs are stable half a cycle after the edge
	always @(negedge clk) begin
		if (wb_valid === 1'b1) begin
			if (exp_cycle.size() == 0) begin
				$display("Unexpected writeback to r%0d at cycle %0d", wb_rd, cycle);
				protocol_errors++;
			end else begin
				if (exp_cycle[0] != cycle) begin
					$display("Writeback came at cycle %0d instead of cycle %0d",
						cycle, exp_cycle[0]);
					protocol_errors++;
				end
				check_rd(wb_rd, exp_rd[0]);
				check_data(wb_data, exp_data[0]);
				checked++;
				drop_head();
			end
		end else if (exp_cycle.size() > 0 && exp_cycle[0] <= cycle) begin
			$display("Missing writeback to r%0d due at cycle %0d", exp_rd[0], exp_cycle[0]);
			protocol_errors++;
			drop_head();
		end
	end

	initial begin
		int base;
		int waited;
		int drain_errors;
		clk = 1'b0;
		rst = 1'b1;
		instr_valid = 1'b0;
		instr = '0;
		drain_errors = 0;
		$readmemh("tests/wisc_core_vectors.txt", vec_mem);
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		for (int i = 0; i < NUM_VEC; i++) begin
			base = 4 * i;
			@(posedge clk);
			#1;
			instr_valid = vec_mem[base][0];
			instr = vec_mem[base+1][15:0];
			if (vec_mem[base+2][0]) begin
				exp_cycle.push_back(cycle + LATENCY);	// Sampled at the next edge
				exp_rd.push_back(vec_mem[base+3][19:16]);
				exp_data.push_back(vec_mem[base+3][15:0]);
			end
		end
		@(posedge clk);
		#1;
		instr_valid = 1'b0;
		instr = '0;
		waited = 0;
		while (exp_cycle.size() > 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (exp_cycle.size() > 0) begin
			$display("Timeout: %0d writebacks still outstanding after %0d cycles",
				exp_cycle.size(), DRAIN_LIMIT);
			drain_errors++;
		end
		repeat (4) @(posedge clk);	// Catch stray writebacks
		$display("Errors: %0d value, %0d protocol, %0d timeout; %0d writebacks checked",
			value_errors, protocol_errors, drain_errors, checked);
		if (value_errors == 0 && protocol_errors == 0 && drain_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

/* tests/wisc_core_vectors.txt */
// Columns: valid, instruction, expect writeback, expected rd nibble then 16-bit data
// One entry per cycle; entries with expect 0 must produce no writeback
0 0000 0 00000
1 7105 1 10005
1 72FE 1 2FFFE
1 7380 1 3FF80
1 8312 1 31280
1 0412 1 40003
1 1512 1 50007
1 2632 1 61280
1 3713 1 7ED7A
1 4834 1 82800
1 4920 1 9FFFE
1 4A1F 1 A8000
1 5B2F 1 B0001
1 5C30 1 C1280
1 6D2F 1 DFFFF
1 6E74 1 EFED7
1 6F3F 1 F0000
1 6F30 1 F1280
1 7110 1 10010
1 0111 1 10020
1 0211 1 20040
1 1312 1 3FFE0
1 7401 1 40001
1 7402 1 40002
1 0544 1 50004
1 2645 1 60000
1 F123 0 00000
1 9145 0 00000
1 B711 0 00000
1 7055 0 00000
1 0705 1 70004
1 0012 0 00000
1 3800 1 8FFFF
0 0000 0 00000
0 7155 0 00000
1 0918 1 9001F
1 89AB 1 9AB1F
1 5A98 1 A00AB
